// ==== build.f ====
src/msg_net_pkg.sv
src/msg_source.sv
src/msg_fifo.sv
src/msg_sink.sv
src/msg_checker.sv
src/dbg_display.sv
src/msg_loop_top.sv
test/msg_loop_asserts.sv
test/msg_loop_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= msg_loop_tb
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SHELL := /bin/bash

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run, and scan $(LOG) for the fail message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	set -o pipefail; ./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then \
		echo "Simulation reported failure"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== test/msg_loop_tb.sv ====
module msg_loop_tb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int WAIT_LIMIT = 200;

	typedef enum int {
		corr_none,
		corr_src,
		corr_dat,
		corr_red,
		corr_drop
	} corr_t;

	typedef enum int {
		sig_o0_req,
		sig_i0_ack,
		sig_drained
	} probe_t;

	logic                        i_clk;
	logic                        arst_n;
	logic                        run;
	logic [7:0]                  dbg_case;
	logic                        o0_req;
	logic [msg_net_pkg::ASZ-1:0] o0_src;
	logic [msg_net_pkg::ASZ-1:0] o0_dst;
	logic [msg_net_pkg::DSZ-1:0] o0_dat;
	logic [msg_net_pkg::RSZ-1:0] o0_red;
	logic                        o0_ack;
	logic                        i0_req;
	logic [msg_net_pkg::ASZ-1:0] i0_src;
	logic [msg_net_pkg::ASZ-1:0] i0_dst;
	logic [msg_net_pkg::DSZ-1:0] i0_dat;
	logic [msg_net_pkg::RSZ-1:0] i0_red;
	logic                        i0_ack;
	logic [3:0]                  dbg_leds;
	logic [3:0]                  dbg_disp0;
	logic [3:0]                  dbg_disp1;

	logic [31:0] rng_state;
	int          err_cnt;
	int          chk_cnt;
	bit          long_holds;

	// Generator model
	logic [msg_net_pkg::ASZ-1:0] gen_dst;
	logic [msg_net_pkg::DSZ-1:0] gen_dat;
	logic [3:0]                  gen_sent;
	logic [3:0]                  gen_last;

	// Checker model
	logic [msg_net_pkg::DSZ-1:0] exp_dat;
	logic [3:0]                  exp_flags;
	logic [3:0]                  exp_info0;
	logic [3:0]                  exp_info1;

	logic [msg_net_pkg::MSG_W-1:0] sent_q[$];

	msg_loop_top i_msg_loop_top (.*);

	initial begin
		i_clk = 1'b0;
		forever #2 i_clk = ~i_clk;
	end

	function automatic logic [31:0] rand_next();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	// XOR of all nibbles, 6-bit addresses padded to a byte
	function automatic logic [3:0] nibble_xor(
		input logic [5:0] src,
		input logic [5:0] dst,
		input logic [7:0] dat
	);
		return src[3:0] ^ {2'b00, src[5:4]} ^ dst[3:0] ^ {2'b00, dst[5:4]} ^
			dat[3:0] ^ dat[7:4];
	endfunction

	function automatic bit probe(input probe_t which);
		case (which)
			sig_o0_req: return o0_req;
			sig_i0_ack: return i0_ack;
			default: return i_msg_loop_top.i_msg_sink.empty && !i_msg_loop_top.pop_valid;
		endcase
	endfunction

	task automatic expect_true(input bit cond, input string msg);
		chk_cnt++;
		assert (cond) else begin
			err_cnt++;
			$display("CHECK FAILED at %0d ns: %s", $time, msg);
		end
	endtask

	task automatic wait_until(input probe_t which, input bit level, input string what);
		int n;
		n = 0;
		while (probe(which) != level && n < WAIT_LIMIT) begin
			@(negedge i_clk);
			n++;
		end
		if (probe(which) != level) begin
			$display("Timed out after %0d cycles waiting for %s", WAIT_LIMIT, what);
			$display("TEST FAILED");
			$finish;
		end
	endtask

	task automatic pause_random();
		int n;
		if (long_holds) begin
			n = 8 + int'(rand_next() % 8);
		end else begin
			n = int'(rand_next() % 4);
		end
		repeat (n) @(negedge i_clk);
	endtask

	task automatic apply_reset();
		run = 1'b0;
		arst_n = 1'b0;
		repeat (8) @(negedge i_clk);
		arst_n = 1'b1;
		gen_dst = msg_net_pkg::MIN_ADDR;
		gen_dat = '0;
		gen_sent = '0;
		gen_last = '0;
		exp_dat = '0;
		exp_flags = '0;
		exp_info0 = '0;
		exp_info1 = '0;
		sent_q.delete();
	endtask

	// Checker rules applied to each delivered message
	task automatic model_checker(
		input logic [5:0] src,
		input logic [5:0] dst,
		input logic [7:0] dat,
		input logic [3:0] red
	);
		if (src != msg_net_pkg::SRC_ADDR) begin
			if (!exp_flags[0]) begin
				exp_info0 = src[3:0];
			end
			exp_flags[0] = 1'b1;
		end
		if (dat != exp_dat) begin
			if (!exp_flags[1]) begin
				exp_info1 = dst[3:0];
			end
			exp_flags[1] = 1'b1;
		end
		if (red != nibble_xor(src, dst, dat)) begin
			exp_flags[2] = 1'b1;
		end
		exp_flags[3] = 1'b1;
		exp_dat = dat + 1'b1;
	endtask

	// Serve one o0 message and copy it to i0, possibly damaged
	task automatic loop_one(input corr_t corr);
		logic [msg_net_pkg::ASZ-1:0] src;
		logic [msg_net_pkg::ASZ-1:0] dst;
		logic [msg_net_pkg::DSZ-1:0] dat;
		logic [msg_net_pkg::RSZ-1:0] red;
		logic [msg_net_pkg::RSZ-1:0] exp_red;
		logic [31:0]                 mask;
		wait_until(sig_o0_req, 1'b1, "o0_req to rise");
		exp_red = nibble_xor(msg_net_pkg::SRC_ADDR, gen_dst, gen_dat);
		expect_true(o0_src == msg_net_pkg::SRC_ADDR, $sformatf("o0_src is %0d", o0_src));
		expect_true(o0_dst == gen_dst, $sformatf("o0_dst %0d, expected %0d", o0_dst, gen_dst));
		expect_true(o0_dat == gen_dat, $sformatf("o0_dat %0d, expected %0d", o0_dat, gen_dat));
		expect_true(o0_red == exp_red,
			$sformatf("o0_red %h, expected %h", o0_red, exp_red));
		sent_q.push_back({o0_src, o0_dst, o0_dat, o0_red});
		gen_sent = gen_sent + 1'b1;
		gen_last = gen_dst[3:0];
		gen_dst = (gen_dst == msg_net_pkg::MAX_ADDR) ? msg_net_pkg::MIN_ADDR : gen_dst + 1'b1;
		gen_dat = gen_dat + 1'b1;
		pause_random();
		{src, dst, dat, red} = sent_q.pop_front();
		// Bit 0 always set so the mask is never zero
		mask = rand_next() | 32'h1;
		case (corr)
			corr_src: src = src ^ mask[5:0];
			corr_dat: dat = dat ^ mask[7:0];
			corr_red: red = red ^ mask[3:0];
			default: ;
		endcase
		if (corr != corr_drop) begin
			i0_src = src;
			i0_dst = dst;
			i0_dat = dat;
			i0_red = red;
			i0_req = 1'b1;
			wait_until(sig_i0_ack, 1'b1, "i0_ack to rise");
			pause_random();
			i0_req = 1'b0;
			wait_until(sig_i0_ack, 1'b0, "i0_ack to fall");
			model_checker(src, dst, dat, red);
		end
		pause_random();
		o0_ack = 1'b1;
		wait_until(sig_o0_req, 1'b0, "o0_req to fall");
		pause_random();
		o0_ack = 1'b0;
	endtask

	task automatic check_sink_page();
		dbg_case = 8'(4 + rand_next() % 252);
		wait_until(sig_drained, 1'b1, "the receiver FIFO to drain");
		// Checker then display register
		repeat (2) @(negedge i_clk);
		expect_true(dbg_leds == exp_flags, $sformatf("flags %b, expected %b", dbg_leds, exp_flags));
		expect_true(dbg_disp0 == exp_info0, $sformatf("digit 0 %h, expected %h", dbg_disp0, exp_info0));
		expect_true(dbg_disp1 == exp_info1, $sformatf("digit 1 %h, expected %h", dbg_disp1, exp_info1));
	endtask

	task automatic check_source_page();
		dbg_case = 8'(rand_next() % 4);
		repeat (2) @(negedge i_clk);
		expect_true(dbg_leds == gen_sent, $sformatf("sent count %0d, expected %0d", dbg_leds, gen_sent));
		expect_true(dbg_disp0 == gen_last, $sformatf("last dst %h, expected %h", dbg_disp0, gen_last));
		expect_true(dbg_disp1 == 4'h0, "digit 1 not zero on the source page");
	endtask

	initial begin
		rng_state = 32'd29;
		err_cnt = 0;
		chk_cnt = 0;
		long_holds = 1'b0;
		run = 1'b0;
		dbg_case = 8'd4;
		o0_ack = 1'b0;
		i0_req = 1'b0;
		i0_src = '0;
		i0_dst = '0;
		i0_dat = '0;
		i0_red = '0;
		apply_reset();
		expect_true(!o0_req && !i0_ack, "handshake outputs high after reset");
		expect_true(dbg_leds == 4'h0 && dbg_disp0 == 4'h0 && dbg_disp1 == 4'h0,
			"display outputs not zero after reset");
		run = 1'b1;

		// Clean loopback
		repeat (40) loop_one(corr_none);
		check_sink_page();
		expect_true(dbg_leds == 4'b1000, "clean run did not give flags 1000");

		// Long holds on both channels
		long_holds = 1'b1;
		repeat (12) loop_one(corr_none);
		long_holds = 1'b0;
		check_sink_page();
		expect_true(!dbg_leds[1], "message lost or duplicated under back-pressure");

		// Source corruption, then clean traffic
		loop_one(corr_src);
		repeat (5) loop_one(corr_none);
		check_sink_page();
		expect_true(dbg_leds[0], "source error flag not set or not sticky");

		apply_reset();
		run = 1'b1;
		repeat (3) loop_one(corr_none);
		loop_one(corr_dat);
		repeat (3) loop_one(corr_none);
		check_sink_page();
		expect_true(dbg_leds[1], "data error flag not set by corrupted data");

		apply_reset();
		run = 1'b1;
		repeat (3) loop_one(corr_none);
		loop_one(corr_drop);
		repeat (3) loop_one(corr_none);
		check_sink_page();
		expect_true(dbg_leds[1], "data error flag not set by a dropped message");
		loop_one(corr_red);
		repeat (2) loop_one(corr_none);
		check_sink_page();
		expect_true(dbg_leds[2], "redundancy error flag not set");

		// Stop the generator and finish any message already issued
		run = 1'b0;
		repeat (2) @(negedge i_clk);
		if (o0_req) begin
			loop_one(corr_none);
		end
		repeat (30) begin
			@(negedge i_clk);
			expect_true(!o0_req, "o0_req rose with run low");
		end
		check_source_page();
		check_sink_page();

		$display("Checks: %0d, errors: %0d", chk_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// ==== test/msg_loop_asserts.sv ====
module msg_loop_asserts (
	input logic                          i_clk,
	input logic                          arst_n,
	input logic                          o0_req,
	input logic                          o0_ack,
	input logic [msg_net_pkg::MSG_W-1:0] o0_fields,
	input logic                          i0_req,
	input logic                          i0_ack,
	input logic                          fifo_full
);

	timeunit 1ns;
	timeprecision 100ps;

	// Fields hold for as long as a request is outstanding
	o0_stable: assert property (@(posedge i_clk) disable iff (!arst_n)
		o0_req && $past(o0_req) |-> o0_fields == $past(o0_fields))
		else $error("o0 fields changed while o0_req was high");

	// New request only once the previous ack is gone
	o0_new_req: assert property (@(posedge i_clk) disable iff (!arst_n)
		$rose(o0_req) |-> !$past(o0_ack))
		else $error("o0_req rose while o0_ack was high");

	// Ack needs a pending request and room in the FIFO
	i0_ack_rise: assert property (@(posedge i_clk) disable iff (!arst_n)
		$rose(i0_ack) |-> $past(i0_req && !fifo_full))
		else $error("i0_ack rose without request or with FIFO full");

	i0_ack_fall: assert property (@(posedge i_clk) disable iff (!arst_n)
		$fell(i0_ack) |-> $past(!i0_req))
		else $error("i0_ack fell while i0_req was still high");

endmodule

bind msg_loop_top msg_loop_asserts i_msg_loop_asserts (
	.i_clk     (i_clk),
	.arst_n    (arst_n),
	.o0_req    (o0_req),
	.o0_ack    (o0_ack),
	.o0_fields ({o0_src, o0_dst, o0_dat, o0_red}),
	.i0_req    (i0_req),
	.i0_ack    (i0_ack),
	.fifo_full (i_msg_sink.full)
);

// ==== src/msg_loop_top.sv ====
module msg_loop_top (
	input  logic                        i_clk,
	input  logic                        arst_n,
	input  logic                        run,
	input  logic [7:0]                  dbg_case,
	output logic                        o0_req,
	output logic [msg_net_pkg::ASZ-1:0] o0_src,
	output logic [msg_net_pkg::ASZ-1:0] o0_dst,
	output logic [msg_net_pkg::DSZ-1:0] o0_dat,
	output logic [msg_net_pkg::RSZ-1:0] o0_red,
	input  logic                        o0_ack,
	input  logic                        i0_req,
	input  logic [msg_net_pkg::ASZ-1:0] i0_src,
	input  logic [msg_net_pkg::ASZ-1:0] i0_dst,
	input  logic [msg_net_pkg::DSZ-1:0] i0_dat,
	input  logic [msg_net_pkg::RSZ-1:0] i0_red,
	output logic                        i0_ack,
	output logic [3:0]                  dbg_leds,
	output logic [3:0]                  dbg_disp0,
	output logic [3:0]                  dbg_disp1
);

	logic [3:0] sent_cnt;
	logic [3:0] last_dst;

	// Strobe from receiver to checker
	logic                        pop_valid;
	logic [msg_net_pkg::ASZ-1:0] pop_src;
	logic [msg_net_pkg::ASZ-1:0] pop_dst;
	logic [msg_net_pkg::DSZ-1:0] pop_dat;
	logic [msg_net_pkg::RSZ-1:0] pop_red;

	logic [3:0] err_flags;
	logic [3:0] info_0;
	logic [3:0] info_1;

	msg_source i_msg_source (
		.i_clk    (i_clk),
		.arst_n   (arst_n),
		.run      (run),
		.o0_ack   (o0_ack),
		.o0_req   (o0_req),
		.o0_src   (o0_src),
		.o0_dst   (o0_dst),
		.o0_dat   (o0_dat),
		.o0_red   (o0_red),
		.sent_cnt (sent_cnt),
		.last_dst (last_dst)
	);

	msg_sink i_msg_sink (
		.i_clk     (i_clk),
		.arst_n    (arst_n),
		.i0_req    (i0_req),
		.i0_src    (i0_src),
		.i0_dst    (i0_dst),
		.i0_dat    (i0_dat),
		.i0_red    (i0_red),
		.i0_ack    (i0_ack),
		.pop_valid (pop_valid),
		.pop_src   (pop_src),
		.pop_dst   (pop_dst),
		.pop_dat   (pop_dat),
		.pop_red   (pop_red)
	);

	msg_checker i_msg_checker (
		.i_clk     (i_clk),
		.arst_n    (arst_n),
		.pop_valid (pop_valid),
		.pop_src   (pop_src),
		.pop_dst   (pop_dst),
		.pop_dat   (pop_dat),
		.pop_red   (pop_red),
		.err_flags (err_flags),
		.info_0    (info_0),
		.info_1    (info_1)
	);

	dbg_display i_dbg_display (
		.i_clk     (i_clk),
		.arst_n    (arst_n),
		.dbg_case  (dbg_case),
		.sent_cnt  (sent_cnt),
		.last_dst  (last_dst),
		.err_flags (err_flags),
		.info_0    (info_0),
		.info_1    (info_1),
		.dbg_leds  (dbg_leds),
		.dbg_disp0 (dbg_disp0),
		.dbg_disp1 (dbg_disp1)
	);

endmodule

// ==== src/dbg_display.sv ====
module dbg_display (
	input  logic       i_clk,
	input  logic       arst_n,
	input  logic [7:0] dbg_case,
	input  logic [3:0] sent_cnt,
	input  logic [3:0] last_dst,
	input  logic [3:0] err_flags,
	input  logic [3:0] info_0,
	input  logic [3:0] info_1,
	output logic [3:0] dbg_leds,
	output logic [3:0] dbg_disp0,
	output logic [3:0] dbg_disp1
);

	msg_net_pkg::dbg_page_t page;

	assign page = (dbg_case < msg_net_pkg::DBG_MAX_SRC_CASE) ?
		msg_net_pkg::page_source : msg_net_pkg::page_sink;

	always_ff @(posedge i_clk or negedge arst_n) begin
		if (!arst_n) begin
			dbg_leds <= '0;
			dbg_disp0 <= '0;
			dbg_disp1 <= '0;
		end else begin
			case (page)
				msg_net_pkg::page_source: begin
					dbg_leds <= sent_cnt;
					dbg_disp0 <= last_dst;
					dbg_disp1 <= '0;
				end
				default: begin
					// Sink page
					dbg_leds <= err_flags;
					dbg_disp0 <= info_0;
					dbg_disp1 <= info_1;
				end
			endcase
		end
	end

endmodule

// ==== src/msg_checker.sv ====
module msg_checker (
	input  logic                        i_clk,
	input  logic                        arst_n,
	input  logic                        pop_valid,
	input  logic [msg_net_pkg::ASZ-1:0] pop_src,
	input  logic [msg_net_pkg::ASZ-1:0] pop_dst,
	input  logic [msg_net_pkg::DSZ-1:0] pop_dat,
	input  logic [msg_net_pkg::RSZ-1:0] pop_red,
	output logic [3:0]                  err_flags,
	output logic [3:0]                  info_0,
	output logic [3:0]                  info_1
);

	logic [msg_net_pkg::DSZ-1:0] exp_dat;

	logic bad_src;
	logic bad_dat;
	logic bad_red;

	assign bad_src = (pop_src != msg_net_pkg::SRC_ADDR);
	assign bad_dat = (pop_dat != exp_dat);
	assign bad_red = (pop_red != msg_net_pkg::calc_redun(pop_src, pop_dst, pop_dat));

	always_ff @(posedge i_clk or negedge arst_n) begin
		if (!arst_n) begin
			err_flags <= '0;
			info_0 <= '0;
			info_1 <= '0;
			exp_dat <= '0;
		end else if (pop_valid) begin
			// Info nibbles hold the first offender only
			if (bad_src) begin
				err_flags[0] <= 1'b1;
				if (!err_flags[0]) begin
					info_0 <= pop_src[3:0];
				end
			end
			if (bad_dat) begin
				err_flags[1] <= 1'b1;
				if (!err_flags[1]) begin
					info_1 <= pop_dst[3:0];
				end
			end
			if (bad_red) begin
				err_flags[2] <= 1'b1;
			end
			err_flags[3] <= 1'b1;
			// Resync on whatever arrived so one gap is not reported forever
			exp_dat <= pop_dat + 1'b1;
		end
	end

endmodule

// ==== src/msg_sink.sv ====
module msg_sink (
	input  logic                        i_clk,
	input  logic                        arst_n,
	input  logic                        i0_req,
	input  logic [msg_net_pkg::ASZ-1:0] i0_src,
	input  logic [msg_net_pkg::ASZ-1:0] i0_dst,
	input  logic [msg_net_pkg::DSZ-1:0] i0_dat,
	input  logic [msg_net_pkg::RSZ-1:0] i0_red,
	output logic                        i0_ack,
	output logic                        pop_valid,
	output logic [msg_net_pkg::ASZ-1:0] pop_src,
	output logic [msg_net_pkg::ASZ-1:0] pop_dst,
	output logic [msg_net_pkg::DSZ-1:0] pop_dat,
	output logic [msg_net_pkg::RSZ-1:0] pop_red
);

	logic                          wr_en;
	logic                          rd_en;
	logic [msg_net_pkg::MSG_W-1:0] rd_data;
	logic                          empty;
	logic                          full;

	// Take a message only on the rising side of the handshake
	assign wr_en = i0_req && !i0_ack && !full;
	assign rd_en = !empty;

	msg_fifo i_msg_fifo (
		.i_clk   (i_clk),
		.arst_n  (arst_n),
		.wr_en   (wr_en),
		.wr_data ({i0_src, i0_dst, i0_dat, i0_red}),
		.rd_en   (rd_en),
		.rd_data (rd_data),
		.empty   (empty),
		.full    (full)
	);

	always_ff @(posedge i_clk or negedge arst_n) begin
		if (!arst_n) begin
			i0_ack <= 1'b0;
			pop_valid <= 1'b0;
		end else begin
			if (wr_en) begin
				i0_ack <= 1'b1;
			end else if (i0_ack && !i0_req) begin
				i0_ack <= 1'b0;
			end
			pop_valid <= rd_en;
		end
	end

	always_ff @(posedge i_clk) begin
		if (rd_en) begin
			{pop_src, pop_dst, pop_dat, pop_red} <= rd_data;
		end
	end

endmodule

// ==== src/msg_fifo.sv ====
module msg_fifo (
	input  logic                          i_clk,
	input  logic                          arst_n,
	input  logic                          wr_en,
	input  logic [msg_net_pkg::MSG_W-1:0] wr_data,
	input  logic                          rd_en,
	output logic [msg_net_pkg::MSG_W-1:0] rd_data,
	output logic                          empty,
	output logic                          full
);

	logic [msg_net_pkg::MSG_W-1:0] mem [msg_net_pkg::FIFO_DEPTH];

	logic [$clog2(msg_net_pkg::FIFO_DEPTH)-1:0] head;
	logic [$clog2(msg_net_pkg::FIFO_DEPTH)-1:0] tail;
	logic [$clog2(msg_net_pkg::FIFO_DEPTH+1)-1:0] count;

	logic do_wr;
	logic do_rd;

	assign empty = (count == 0);
	assign full = (count == msg_net_pkg::FIFO_DEPTH);
	assign do_wr = wr_en && !full;
	assign do_rd = rd_en && !empty;

	// Show-ahead read of the oldest entry
	assign rd_data = mem[head];

	always_ff @(posedge i_clk) begin
		if (do_wr) begin
			mem[tail] <= wr_data;
		end
	end

	always_ff @(posedge i_clk or negedge arst_n) begin
		if (!arst_n) begin
			head <= '0;
			tail <= '0;
			count <= '0;
		end else begin
			if (do_wr) begin
				tail <= (tail == msg_net_pkg::FIFO_DEPTH - 1) ? '0 : tail + 1'b1;
			end
			if (do_rd) begin
				head <= (head == msg_net_pkg::FIFO_DEPTH - 1) ? '0 : head + 1'b1;
			end
			// Simultaneous read and write leaves the count alone
			if (do_wr && !do_rd) begin
				count <= count + 1'b1;
			end else if (do_rd && !do_wr) begin
				count <= count - 1'b1;
			end
		end
	end

endmodule

// ==== src/msg_source.sv ====
module msg_source (
	input  logic                        i_clk,
	input  logic                        arst_n,
	input  logic                        run,
	input  logic                        o0_ack,
	output logic                        o0_req,
	output logic [msg_net_pkg::ASZ-1:0] o0_src,
	output logic [msg_net_pkg::ASZ-1:0] o0_dst,
	output logic [msg_net_pkg::DSZ-1:0] o0_dat,
	output logic [msg_net_pkg::RSZ-1:0] o0_red,
	output logic [3:0]                  sent_cnt,
	output logic [3:0]                  last_dst
);

	typedef enum logic {
		st_idle,
		st_req
	} src_state_t;

	src_state_t state;

	// Fields of the message to be sent next
	logic [msg_net_pkg::ASZ-1:0] nxt_dst;
	logic [msg_net_pkg::DSZ-1:0] nxt_dat;

	assign o0_src = msg_net_pkg::SRC_ADDR;
	assign o0_req = (state == st_req);
	assign last_dst = o0_dst[3:0];

	always_ff @(posedge i_clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= st_idle;
			nxt_dst <= msg_net_pkg::MIN_ADDR;
			nxt_dat <= '0;
			o0_dst <= '0;
			o0_dat <= '0;
			o0_red <= '0;
			sent_cnt <= '0;
		end else begin
			case (state)
				st_idle: begin
					// Far side must have released ack from the previous message
					if (run && !o0_ack) begin
						o0_dst <= nxt_dst;
						o0_dat <= nxt_dat;
						o0_red <= msg_net_pkg::calc_redun(msg_net_pkg::SRC_ADDR, nxt_dst, nxt_dat);
						nxt_dst <= (nxt_dst >= msg_net_pkg::MAX_ADDR) ?
							msg_net_pkg::MIN_ADDR : nxt_dst + 1'b1;
						nxt_dat <= nxt_dat + 1'b1;
						// Counted when the message is issued
						sent_cnt <= sent_cnt + 1'b1;
						state <= st_req;
					end
				end
				st_req: begin
					if (o0_ack) begin
						state <= st_idle;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

endmodule

// ==== src/msg_net_pkg.sv ====
package msg_net_pkg;

	// Message field widths
	localparam int ASZ = 6;
	localparam int DSZ = 8;
	localparam int RSZ = 4;
	localparam int MSG_W = 2 * ASZ + DSZ + RSZ;

	localparam int FIFO_DEPTH = 4;

	// Destination range walked by the generator
	localparam logic [ASZ-1:0] MIN_ADDR = 6'd1;
	localparam logic [ASZ-1:0] MAX_ADDR = 6'd5;

	// This endpoint's own address
	localparam logic [ASZ-1:0] SRC_ADDR = 6'd3;

	// Debug cases below this value select the generator page
	localparam logic [7:0] DBG_MAX_SRC_CASE = 8'd4;

	typedef enum logic {
		page_source,
		page_sink
	} dbg_page_t;

	// XOR fold of all nibbles, addresses zero padded to a byte
	function automatic logic [RSZ-1:0] calc_redun(
		input logic [ASZ-1:0] src,
		input logic [ASZ-1:0] dst,
		input logic [DSZ-1:0] dat
	);
		logic [7:0] src8;
		logic [7:0] dst8;
		src8 = {{(8 - ASZ){1'b0}}, src};
		dst8 = {{(8 - ASZ){1'b0}}, dst};
		return src8[3:0] ^ src8[7:4] ^ dst8[3:0] ^ dst8[7:4] ^ dat[3:0] ^ dat[7:4];
	endfunction

endpackage
